/* mousePkg.sv */
package mousePkg;

	// ----------------------------------------
	// Types
	// ----------------------------------------
	typedef logic [7:0] ps2Byte;
	typedef logic [9:0] coordX;
	typedef logic [9:0] coordY;
	// Sign bit from the status byte, then the data byte
	typedef logic signed [8:0] mouseDelta;
	// Bit 0 left, bit 1 right, bit 2 middle
	typedef logic [2:0] buttonSet;
	// RRRGGGBB
	typedef logic [7:0] rgbPixel;

	typedef enum logic [2:0] {
		SendEnable,
		WaitSent,
		WaitAck,
		WaitStatus,
		WaitDx,
		WaitDy,
		Fault
	} seqState;

	// ----------------------------------------
	// Screen and raster timing
	// ----------------------------------------
	localparam int HVisible = 640;
	localparam int VVisible = 480;
	localparam int HFront = 16;
	localparam int HSync = 96;
	localparam int HBack = 48;
	localparam int HTotal = 800;
	localparam int VFront = 10;
	localparam int VSync = 2;
	localparam int VBack = 33;
	localparam int VTotal = 525;

	// ----------------------------------------
	// Mouse protocol and display constants
	// ----------------------------------------
	localparam ps2Byte CmdEnable = 8'hF4;
	localparam ps2Byte RespAck = 8'hFA;
	localparam int CursorSize = 8;
	localparam rgbPixel CursorColour = 8'hFF;
	localparam rgbPixel BackColour = 8'h03;
	localparam int FilterDepth = 8;
	// About 100 us at 25 MHz
	localparam int InhibitCycles = 2600;

endpackage

/* ps2ClockFilter.sv */
`timescale 1ns/1ps

module ps2ClockFilter (
	input logic CLK0,
	input logic reset,
	input logic ps2ClkIn,
	output logic ps2ClkLevel,
	output logic ps2ClkFall
);
	import mousePkg::*;

	logic [FilterDepth-1:0] samples;
	logic levelPrev;

	always_ff @(posedge CLK0) begin
		if (reset) begin
			// Idle bus floats high
			samples <= '1;
			ps2ClkLevel <= 1'b1;
			levelPrev <= 1'b1;
		end else begin
			samples <= {samples[FilterDepth-2:0], ps2ClkIn};
			levelPrev <= ps2ClkLevel;
			// Hysteresis, level only moves on a full run of equal samples
			if (samples == '1) begin
				ps2ClkLevel <= 1'b1;
			end else if (samples == '0) begin
				ps2ClkLevel <= 1'b0;
			end
		end
	end

	// One cycle wide, right after the level drops
	assign ps2ClkFall = levelPrev & ~ps2ClkLevel;

endmodule

/* ps2Receiver.sv */
`timescale 1ns/1ps

module ps2Receiver (
	input logic CLK0,
	input logic reset,
	input logic ps2ClkFall,
	input logic ps2DataIn,
	input logic rxEnable,
	output logic rxValid,
	output mousePkg::ps2Byte rxByte,
	output logic rxError
);
	import mousePkg::*;

	logic [3:0] bitCount;
	logic [9:0] frame;
	logic [10:0] nextFrame;
	logic lastBit;
	logic frameOk;

	// Bits arrive LSB first and enter at the top
	assign nextFrame = {ps2DataIn, frame};
	assign lastBit = ps2ClkFall && (bitCount == 4'd10);

	// Start low, odd parity over data and parity bit, stop high
	assign frameOk = !nextFrame[0] && (^nextFrame[9:1]) && nextFrame[10];

	// ----------------------------------------
	// Frame counter and strobes
	// ----------------------------------------
	always_ff @(posedge CLK0) begin
		if (reset || !rxEnable) begin
			bitCount <= '0;
			rxValid <= 1'b0;
			rxError <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			rxError <= 1'b0;
			if (ps2ClkFall) begin
				if (lastBit) begin
					bitCount <= '0;
					rxValid <= frameOk;
					rxError <= !frameOk;
				end else begin
					bitCount <= bitCount + 4'd1;
				end
			end
		end
	end

	// ----------------------------------------
	// Shift register and byte output
	// ----------------------------------------
	always_ff @(posedge CLK0) begin
		if (!rxEnable) begin
			frame <= '0;
		end else if (ps2ClkFall) begin
			frame <= nextFrame[10:1];
		end
		if (rxEnable && lastBit) begin
			rxByte <= nextFrame[8:1];
		end
	end

endmodule

/* ps2Transmitter.sv */
`timescale 1ns/1ps

module ps2Transmitter (
	input logic CLK0,
	input logic reset,
	input logic ps2ClkFall,
	input logic ps2DataIn,
	input logic txStart,
	input mousePkg::ps2Byte txByte,
	output logic ps2ClkPull,
	output logic ps2DataPull,
	output logic txBusy,
	output logic txDone
);
	import mousePkg::*;

	typedef enum logic [1:0] {
		TxIdle,
		TxInhibit,
		TxShift,
		TxAck
	} txState;

	txState state;
	logic [$clog2(InhibitCycles)-1:0] inhibitCount;
	logic [3:0] bitCount;
	ps2Byte heldByte;
	logic [9:0] frameBits;

	// Data LSB first, odd parity, then the released stop bit
	assign frameBits = {1'b1, ~^heldByte, heldByte};
	assign txBusy = (state != TxIdle);

	always_ff @(posedge CLK0) begin
		if (reset) begin
			state <= TxIdle;
			inhibitCount <= '0;
			bitCount <= '0;
			ps2ClkPull <= 1'b0;
			ps2DataPull <= 1'b0;
			txDone <= 1'b0;
		end else begin
			txDone <= 1'b0;
			case (state)
				TxIdle: begin
					if (txStart) begin
						state <= TxInhibit;
						inhibitCount <= '0;
						ps2ClkPull <= 1'b1;
					end
				end
				TxInhibit: begin
					// Falls seen here come from our own clock pull
					if (inhibitCount == InhibitCycles - 1) begin
						// Request to send, start bit low and clock released
						ps2ClkPull <= 1'b0;
						ps2DataPull <= 1'b1;
						bitCount <= '0;
						state <= TxShift;
					end else begin
						inhibitCount <= inhibitCount + 1'b1;
					end
				end
				TxShift: begin
					if (ps2ClkFall) begin
						ps2DataPull <= ~frameBits[bitCount];
						if (bitCount == 4'd9) begin
							state <= TxAck;
						end else begin
							bitCount <= bitCount + 4'd1;
						end
					end
				end
				TxAck: begin
					if (ps2ClkFall) begin
						if (!ps2DataIn) begin
							txDone <= 1'b1;
							state <= TxIdle;
						end else begin
							// No acknowledge, so send the frame again
							state <= TxInhibit;
							inhibitCount <= '0;
							ps2ClkPull <= 1'b1;
						end
					end
				end
				default: state <= TxIdle;
			endcase
		end
	end

	always_ff @(posedge CLK0) begin
		if (state == TxIdle && txStart) begin
			heldByte <= txByte;
		end
	end

endmodule

/* mouseCommandSequencer.sv */
`timescale 1ns/1ps

module mouseCommandSequencer (
	input logic CLK0,
	input logic reset,
	input logic txBusy,
	input logic txDone,
	input logic rxValid,
	input mousePkg::ps2Byte rxByte,
	input logic rxError,
	output logic txStart,
	output mousePkg::ps2Byte txByte,
	output logic rxEnable,
	output logic packetValid,
	output mousePkg::ps2Byte statusByte,
	output mousePkg::ps2Byte dxByte,
	output mousePkg::ps2Byte dyByte
);
	import mousePkg::*;

	seqState state;

	// Receiver stays off while the host owns the bus
	assign rxEnable = ~txStart & ~txBusy & (state != SendEnable);

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge CLK0) begin
		if (reset) begin
			state <= SendEnable;
			txStart <= 1'b0;
			packetValid <= 1'b0;
		end else begin
			txStart <= 1'b0;
			packetValid <= 1'b0;
			case (state)
				SendEnable: begin
					txStart <= 1'b1;
					state <= WaitSent;
				end
				WaitSent: begin
					if (txDone) begin
						state <= WaitAck;
					end
				end
				WaitAck: begin
					if (rxError) begin
						state <= Fault;
					end else if (rxValid) begin
						state <= (rxByte == RespAck) ? WaitStatus : Fault;
					end
				end
				WaitStatus: begin
					// Bit 3 is always set in a real status byte
					if (rxValid && rxByte[3]) begin
						state <= WaitDx;
					end
				end
				WaitDx: begin
					if (rxError) begin
						state <= WaitStatus;
					end else if (rxValid) begin
						state <= WaitDy;
					end
				end
				WaitDy: begin
					if (rxError) begin
						state <= WaitStatus;
					end else if (rxValid) begin
						packetValid <= 1'b1;
						state <= WaitStatus;
					end
				end
				// Fault holds until reset
				default: state <= Fault;
			endcase
		end
	end

	// ----------------------------------------
	// Packet bytes
	// ----------------------------------------
	always_ff @(posedge CLK0) begin
		if (state == SendEnable) begin
			txByte <= CmdEnable;
		end
		if (rxValid) begin
			if (state == WaitStatus && rxByte[3]) begin
				statusByte <= rxByte;
			end
			if (state == WaitDx) begin
				dxByte <= rxByte;
			end
			if (state == WaitDy) begin
				dyByte <= rxByte;
			end
		end
	end

endmodule

/* cursorPosition.sv */
`timescale 1ns/1ps

module cursorPosition (
	input logic CLK0,
	input logic reset,
	input logic packetValid,
	input mousePkg::ps2Byte statusByte,
	input mousePkg::ps2Byte dxByte,
	input mousePkg::ps2Byte dyByte,
	output mousePkg::coordX cursorX,
	output mousePkg::coordY cursorY,
	output mousePkg::buttonSet buttons
);
	import mousePkg::*;

	mouseDelta dx;
	mouseDelta dy;
	logic signed [11:0] sumX;
	logic signed [11:0] sumY;

	function automatic logic [9:0] clampCoord(input logic signed [11:0] value, input int limit);
		if (value < 0) begin
			return '0;
		end else if (value > limit) begin
			return 10'(limit);
		end
		return value[9:0];
	endfunction

	// Sign bits live in the status byte
	assign dx = {statusByte[4], dxByte};
	assign dy = {statusByte[5], dyByte};

	// Mouse Y grows upward, screen Y grows downward
	assign sumX = $signed({2'b00, cursorX}) + dx;
	assign sumY = $signed({2'b00, cursorY}) - dy;

	always_ff @(posedge CLK0) begin
		if (reset) begin
			// Screen centre
			cursorX <= coordX'(HVisible / 2);
			cursorY <= coordY'(VVisible / 2);
			buttons <= '0;
		end else if (packetValid) begin
			cursorX <= coordX'(clampCoord(sumX, HVisible - CursorSize));
			cursorY <= coordY'(clampCoord(sumY, VVisible - CursorSize));
			buttons <= statusByte[2:0];
		end
	end

endmodule

/* vgaCursorRaster.sv */
`timescale 1ns/1ps

module vgaCursorRaster (
	input logic CLK0,
	input logic reset,
	input mousePkg::coordX cursorX,
	input mousePkg::coordY cursorY,
	output logic hSync,
	output logic vSync,
	output mousePkg::rgbPixel pixel
);
	import mousePkg::*;

	coordX hCount;
	coordY vCount;
	logic visible;
	logic inCursor;
	logic hPulse;
	logic vPulse;

	// ----------------------------------------
	// Free-running counters
	// ----------------------------------------
	always_ff @(posedge CLK0) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (hCount == HTotal - 1) begin
			hCount <= '0;
			vCount <= (vCount == VTotal - 1) ? '0 : vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	assign visible = (hCount < HVisible) && (vCount < VVisible);
	assign inCursor = (hCount >= cursorX) && (hCount < cursorX + CursorSize)
		&& (vCount >= cursorY) && (vCount < cursorY + CursorSize);

	// Sync windows sit after the front porch
	assign hPulse = (hCount >= HVisible + HFront) && (hCount < HVisible + HFront + HSync);
	assign vPulse = (vCount >= VVisible + VFront) && (vCount < VVisible + VFront + VSync);

	// ----------------------------------------
	// Output stage, syncs and colour together
	// ----------------------------------------
	always_ff @(posedge CLK0) begin
		if (reset) begin
			hSync <= 1'b1;
			vSync <= 1'b1;
			pixel <= '0;
		end else begin
			hSync <= ~hPulse;
			vSync <= ~vPulse;
			if (!visible) begin
				pixel <= '0;
			end else if (inCursor) begin
				pixel <= CursorColour;
			end else begin
				pixel <= BackColour;
			end
		end
	end

endmodule

/* mouseVgaTop.sv */
`timescale 1ns/1ps

module mouseVgaTop (
	input logic CLK0,
	input logic reset,
	input logic ps2ClkIn,
	input logic ps2DataIn,
	output logic ps2ClkPull,
	output logic ps2DataPull,
	output logic hSync,
	output logic vSync,
	output logic frameError,
	output mousePkg::rgbPixel pixel,
	output mousePkg::coordX cursorX,
	output mousePkg::coordY cursorY,
	output mousePkg::buttonSet buttons
);
	import mousePkg::*;

	logic ps2ClkFall;
	logic rxEnable;
	logic rxValid;
	ps2Byte rxByte;
	logic txStart;
	ps2Byte txByte;
	logic txBusy;
	logic txDone;
	logic packetValid;
	ps2Byte statusByte;
	ps2Byte dxByte;
	ps2Byte dyByte;

	// ----------------------------------------
	// PS/2 side
	// ----------------------------------------
	ps2ClockFilter clockFilter (
		.CLK0(CLK0), .reset(reset), .ps2ClkIn(ps2ClkIn),
		.ps2ClkLevel(), .ps2ClkFall(ps2ClkFall)
	);

	// Frame errors go straight out as frameError
	ps2Receiver receiver (
		.CLK0(CLK0), .reset(reset), .ps2ClkFall(ps2ClkFall), .ps2DataIn(ps2DataIn),
		.rxEnable(rxEnable), .rxValid(rxValid), .rxByte(rxByte), .rxError(frameError)
	);

	ps2Transmitter transmitter (
		.CLK0(CLK0), .reset(reset), .ps2ClkFall(ps2ClkFall), .ps2DataIn(ps2DataIn),
		.txStart(txStart), .txByte(txByte), .ps2ClkPull(ps2ClkPull),
		.ps2DataPull(ps2DataPull), .txBusy(txBusy), .txDone(txDone)
	);

	mouseCommandSequencer sequencer (
		.CLK0(CLK0), .reset(reset), .txBusy(txBusy), .txDone(txDone),
		.rxValid(rxValid), .rxByte(rxByte), .rxError(frameError),
		.txStart(txStart), .txByte(txByte), .rxEnable(rxEnable),
		.packetValid(packetValid), .statusByte(statusByte),
		.dxByte(dxByte), .dyByte(dyByte)
	);

	// ----------------------------------------
	// Cursor and display
	// ----------------------------------------
	cursorPosition position (
		.CLK0(CLK0), .reset(reset), .packetValid(packetValid),
		.statusByte(statusByte), .dxByte(dxByte), .dyByte(dyByte),
		.cursorX(cursorX), .cursorY(cursorY), .buttons(buttons)
	);

	vgaCursorRaster raster (
		.CLK0(CLK0), .reset(reset), .cursorX(cursorX), .cursorY(cursorY),
		.hSync(hSync), .vSync(vSync), .pixel(pixel)
	);

endmodule

/* mouseVgaSva.sv */
`timescale 1ns/1ps

module mouseVgaSva (
	input logic CLK0,
	input logic reset,
	input logic hSync,
	input logic vSync,
	input logic ps2ClkPull,
	input logic ps2DataPull,
	input logic rxEnable
);
	import mousePkg::*;

	int assertFails = 0;
	logic [15:0] hLowCount;
	logic [15:0] vLowCount;

	// Cycles each sync has been low so far
	always_ff @(posedge CLK0) begin
		if (reset) begin
			hLowCount <= '0;
			vLowCount <= '0;
		end else begin
			hLowCount <= hSync ? '0 : hLowCount + 16'd1;
			vLowCount <= vSync ? '0 : vLowCount + 16'd1;
		end
	end

	// ----------------------------------------
	// Sync pulse widths
	// ----------------------------------------
	hSyncWidth: assert property (@(posedge CLK0) disable iff (reset)
		$rose(hSync) |-> hLowCount == HSync)
		else begin
			assertFails++;
			$error("hSync was low for %0d cycles", hLowCount);
		end

	// Whole lines of HTotal cycles
	vSyncWidth: assert property (@(posedge CLK0) disable iff (reset)
		$rose(vSync) |-> vLowCount == VSync * HTotal)
		else begin
			assertFails++;
			$error("vSync was low for %0d cycles", vLowCount);
		end

	// ----------------------------------------
	// Open-drain rules
	// ----------------------------------------
	noDataPullOnReceive: assert property (@(posedge CLK0) disable iff (reset)
		rxEnable |-> !ps2DataPull)
		else begin
			assertFails++;
			$error("ps2DataPull raised while receiving a device frame");
		end

	resetReleasesPulls: assert property (@(posedge CLK0)
		reset |=> !ps2ClkPull && !ps2DataPull)
		else begin
			assertFails++;
			$error("PS/2 pulls still active after reset");
		end

endmodule

bind mouseVgaTop mouseVgaSva checks (
	.CLK0(CLK0), .reset(reset), .hSync(hSync), .vSync(vSync),
	.ps2ClkPull(ps2ClkPull), .ps2DataPull(ps2DataPull), .rxEnable(rxEnable)
);

/* mouseVgaTb.sv */
`timescale 1ns/1ps

module mouseVgaTb;
	import mousePkg::*;

	localparam int HalfBit = 40;
	localparam int LineCycles = HTotal;
	localparam int FrameCycles = HTotal * VTotal;
	// Four frames plus margin for the PS/2 traffic
	localparam int TimeoutCycles = 4 * FrameCycles + 200000;

	logic CLK0 = 1'b0;
	logic reset = 1'b1;
	logic devClkPull = 1'b0;
	logic devDataPull = 1'b0;
	logic ps2ClkLine;
	logic ps2DataLine;
	logic ps2ClkPull;
	logic ps2DataPull;
	logic hSync;
	logic vSync;
	logic frameError;
	rgbPixel pixel;
	coordX cursorX;
	coordY cursorY;
	buttonSet buttons;

	coordX expX = coordX'(320);
	coordY expY = coordY'(240);
	buttonSet expB = '0;
	int seed = 32'h897b30f4;
	int cycle = 0;
	int checkReq = 0;
	int checkDone = 0;
	int errPulses = 0;
	int hostRequests = 0;
	int hFallCycle = -1;
	int vFallCycle = -1;
	int vFalls = 0;
	logic hPrev = 1'b1;
	logic vPrev = 1'b1;
	logic clkPullPrev = 1'b0;

	always #4 CLK0 = ~CLK0;

	// Open-drain lines with pull-ups
	assign ps2ClkLine = !(ps2ClkPull === 1'b1) && !devClkPull;
	assign ps2DataLine = !(ps2DataPull === 1'b1) && !devDataPull;

	mouseVgaTop DUT (
		.CLK0(CLK0), .reset(reset), .ps2ClkIn(ps2ClkLine), .ps2DataIn(ps2DataLine),
		.ps2ClkPull(ps2ClkPull), .ps2DataPull(ps2DataPull), .hSync(hSync),
		.vSync(vSync), .frameError(frameError), .pixel(pixel),
		.cursorX(cursorX), .cursorY(cursorY), .buttons(buttons)
	);

	// ----------------------------------------
	// Error handling and compare tasks
	// ----------------------------------------
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkCoordX(input string name, input coordX got, input coordX exp);
		if (got !== exp) begin
			failRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkCoordY(input string name, input coordY got, input coordY exp);
		if (got !== exp) begin
			failRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkButtons(input string name, input buttonSet got, input buttonSet exp);
		if (got !== exp) begin
			failRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkPixel(input string name, input rgbPixel got, input rgbPixel exp);
		if (got !== exp) begin
			failRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkByte(input string name, input ps2Byte got, input ps2Byte exp);
		if (got !== exp) begin
			failRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic void nextCursor(input coordX x, input coordY y, input ps2Byte st,
			input ps2Byte dxB, input ps2Byte dyB, output coordX nx, output coordY ny);
		int dx;
		int dy;
		int px;
		int py;
		dx = st[4] ? int'(dxB) - 256 : int'(dxB);
		dy = st[5] ? int'(dyB) - 256 : int'(dyB);
		px = int'(x) + dx;
		// Screen Y runs opposite to mouse Y
		py = int'(y) - dy;
		if (px < 0) begin
			px = 0;
		end else if (px > HVisible - CursorSize) begin
			px = HVisible - CursorSize;
		end
		if (py < 0) begin
			py = 0;
		end else if (py > VVisible - CursorSize) begin
			py = VVisible - CursorSize;
		end
		nx = coordX'(px);
		ny = coordY'(py);
	endfunction

	function automatic rgbPixel refPixel(input int h, input int v, input int cx, input int cy);
		if (h >= HVisible || v >= VVisible) begin
			return 8'h00;
		end
		if (h >= cx && h < cx + CursorSize && v >= cy && v < cy + CursorSize) begin
			return CursorColour;
		end
		return BackColour;
	endfunction

	// ----------------------------------------
	// PS/2 device model
	// ----------------------------------------
	task automatic deviceSendByte(input ps2Byte data, input logic goodParity);
		logic [10:0] frame;
		logic parity;
		int i;
		parity = goodParity ? ~^data : ^data;
		frame = {1'b1, parity, data, 1'b0};
		for (i = 0; i < 11; i++) begin
			devDataPull = ~frame[i];
			repeat (HalfBit) @(negedge CLK0);
			devClkPull = 1'b1;
			repeat (HalfBit) @(negedge CLK0);
			devClkPull = 1'b0;
		end
		devDataPull = 1'b0;
		repeat (HalfBit) @(negedge CLK0);
	endtask

	task automatic deviceReceiveByte(output ps2Byte data, output logic parity,
			output logic stopBit);
		logic [9:0] bits;
		int i;
		// Request to send, clock released with data held low
		while (!(ps2ClkLine && !ps2DataLine)) begin
			@(negedge CLK0);
		end
		repeat (HalfBit) @(negedge CLK0);
		for (i = 0; i < 10; i++) begin
			devClkPull = 1'b1;
			repeat (HalfBit) @(negedge CLK0);
			// Sampled just before the rising edge
			bits[i] = ps2DataLine;
			devClkPull = 1'b0;
			repeat (HalfBit) @(negedge CLK0);
		end
		// Acknowledge bit
		devDataPull = 1'b1;
		devClkPull = 1'b1;
		repeat (HalfBit) @(negedge CLK0);
		devClkPull = 1'b0;
		devDataPull = 1'b0;
		repeat (HalfBit) @(negedge CLK0);
		data = bits[7:0];
		parity = bits[8];
		stopBit = bits[9];
	endtask

	task automatic requestCheck();
		checkReq++;
		wait (checkDone == checkReq);
		@(negedge CLK0);
	endtask

	task automatic applyPacket(input ps2Byte st, input ps2Byte dxB, input ps2Byte dyB);
		deviceSendByte(st, 1'b1);
		deviceSendByte(dxB, 1'b1);
		deviceSendByte(dyB, 1'b1);
		nextCursor(expX, expY, st, dxB, dyB, expX, expY);
		expB = st[2:0];
		requestCheck();
	endtask

	task automatic checkCursorPixels();
		int cx;
		int cy;
		int steps;
		cx = int'(expX);
		cy = int'(expY);
		while (!vSync) begin
			@(negedge CLK0);
		end
		while (vSync) begin
			@(negedge CLK0);
		end
		// Now showing counter (0, VVisible + VFront)
		steps = (VTotal - VVisible - VFront) * HTotal + cy * HTotal + cx;
		repeat (steps) @(negedge CLK0);
		checkPixel("pixel at cursor corner", pixel, refPixel(cx, cy, cx, cy));
		repeat (CursorSize) @(negedge CLK0);
		checkPixel("pixel past cursor", pixel, refPixel(cx + CursorSize, cy, cx, cy));
	endtask

	// ----------------------------------------
	// Compare process and monitors
	// ----------------------------------------
	always @(posedge CLK0) begin
		if (checkDone != checkReq) begin
			checkCoordX("cursorX", cursorX, expX);
			checkCoordY("cursorY", cursorY, expY);
			checkButtons("buttons", buttons, expB);
			checkDone <= checkDone + 1;
		end
	end

	always @(posedge CLK0) begin
		cycle++;
		if (cycle >= TimeoutCycles) begin
			failRun($sformatf("Timeout after %0d cycles, the tests did not complete", cycle));
		end
		if (DUT.checks.assertFails != 0) begin
			failRun("An assertion on the sync or PS/2 lines failed");
		end
	end

	always @(negedge CLK0) begin
		if (!reset) begin
			if (hPrev && !hSync) begin
				if (hFallCycle >= 0 && cycle - hFallCycle != LineCycles) begin
					failRun($sformatf("Mismatch hSync fall period: got %h expected %h",
						cycle - hFallCycle, LineCycles));
				end
				hFallCycle = cycle;
			end
			if (vPrev && !vSync) begin
				if (vFallCycle >= 0 && cycle - vFallCycle != FrameCycles) begin
					failRun($sformatf("Mismatch vSync fall period: got %h expected %h",
						cycle - vFallCycle, FrameCycles));
				end
				vFallCycle = cycle;
				vFalls++;
			end
			if (frameError) begin
				errPulses++;
			end
			if (!clkPullPrev && ps2ClkPull) begin
				hostRequests++;
			end
		end
		hPrev = hSync;
		vPrev = vSync;
		clkPullPrev = ps2ClkPull;
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		ps2Byte got;
		logic par;
		logic stopBit;
		ps2Byte st;
		ps2Byte dxB;
		ps2Byte dyB;
		logic [1:0] signs;
		logic [31:0] r;
		int i;
		int errBefore;
		repeat (8) @(negedge CLK0);
		reset = 1'b0;
		requestCheck();

		// Enable command from the host
		deviceReceiveByte(got, par, stopBit);
		checkByte("host frame byte", got, 8'hF4);
		if (^{got, par} !== 1'b1) begin
			failRun("Host frame parity is not odd");
		end
		if (stopBit !== 1'b1) begin
			failRun("Host frame stop bit was not released");
		end
		requestCheck();
		repeat (100) @(negedge CLK0);
		deviceSendByte(8'hFA, 1'b1);

		// Edge runs first, then random moves
		for (i = 0; i < 20; i++) begin
			r = $random(seed);
			if (i < 3) begin
				dxB = 8'hFF;
				dyB = 8'hFF;
				signs = 2'b00;
			end else if (i < 6) begin
				dxB = 8'h00;
				dyB = 8'h00;
				signs = 2'b11;
			end else begin
				dxB = r[7:0];
				dyB = r[15:8];
				signs = r[17:16];
			end
			st = {2'b00, signs[1], signs[0], 1'b1, r[26:24]};
			applyPacket(st, dxB, dyB);
		end

		// Bad parity on the last byte of a packet
		errBefore = errPulses;
		deviceSendByte(8'h08, 1'b1);
		deviceSendByte(8'h10, 1'b1);
		deviceSendByte(8'h20, 1'b0);
		if (errPulses != errBefore + 1) begin
			failRun("frameError did not pulse once for the even parity byte");
		end
		requestCheck();
		applyPacket(8'h09, 8'h05, 8'h03);

		// Stray byte without bit 3 is dropped
		deviceSendByte(8'h02, 1'b1);
		applyPacket(8'h3A, 8'hF0, 8'hF8);

		checkCursorPixels();
		wait (vFalls >= 3);
		@(negedge CLK0);
		if (hostRequests != 1) begin
			failRun($sformatf("Host sent %0d requests instead of exactly one", hostRequests));
		end
		if (DUT.checks.assertFails == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			failRun("An assertion on the sync or PS/2 lines failed");
		end
	end

endmodule

/* build.f */
mousePkg.sv
ps2ClockFilter.sv
ps2Receiver.sv
ps2Transmitter.sv
mouseCommandSequencer.sv
cursorPosition.sv
vgaCursorRaster.sv
mouseVgaTop.sv
mouseVgaSva.sv
mouseVgaTb.sv

/* Bender.yml */
package:
  name: mouse_vga

sources:
  - mousePkg.sv
  - ps2ClockFilter.sv
  - ps2Receiver.sv
  - ps2Transmitter.sv
  - mouseCommandSequencer.sv
  - cursorPosition.sv
  - vgaCursorRaster.sv
  - mouseVgaTop.sv
  - target: test
    files:
      - mouseVgaSva.sv
      - mouseVgaTb.sv
